// File: sources.f
logic/mipsPkg.sv
logic/registerFile.sv
logic/aluUnit.sv
logic/barrelShifter.sv
logic/multiCycleControl.sv
logic/instrDatapath.sv
logic/mipsCore.sv
verification/clockGen.sv
verification/mipsCoreTb.sv

// File: verification/mipsCoreTb.sv
`timescale 1ns/100ps

module mipsCoreTb import mipsPkg::*; ();

    localparam word resetPc   = 32'h40;
    localparam word excVector = 32'h400;

    logic       clk;
    logic       arstN;
    logic       resetReq = 1'b0;
    logic       memWrite;
    word        memRdata = '0;
    word        memAddr;
    word        memWdata;
    word        epc;

    word        image [1024];  // copied into mem while reset is low
    word        mem [1024];
    logic [9:0] prevIdx = '0;

    word        modelRegs [32];
    word        modelMem [1024];
    word        prog [$];
    word        handler [$];
    word        expAddr [$];
    word        expData [$];
    logic       halted;
    word        faultAddr;

    int         cycleCount = 0;
    int         runStart = 0;
    int         cycleLimit = 0;
    logic       timerOn = 1'b0;

    clockGen u_clockGen (.resetReq(resetReq), .clk(clk), .arstN(arstN));

    mipsCore #(.resetPc(resetPc), .excVector(excVector)) u_mipsCore (
        .clk(clk), .arstN(arstN), .memRdata(memRdata), .memAddr(memAddr),
        .memWdata(memWdata), .epc(epc), .memWrite(memWrite)
    );

    // word of the previous cycle's address, driven on the falling edge
    always @(negedge clk) begin
        memRdata <= mem[prevIdx];
        prevIdx  <= memAddr[11:2];
        if (!arstN) begin
            for (int i = 0; i < 1024; i++)
                mem[i] <= image[i];
        end else if (memWrite) begin
            mem[memAddr[11:2]] <= memWdata;
        end
    end

    // store checker
    always @(negedge clk) begin
        if (arstN && memWrite === 1'b1) begin
            if (expAddr.size() == 0) begin
                $display("unexpected store of %h to %h at %0t ns", memWdata, memAddr, $time);
                abortRun();
            end else begin
                checkValue("store address", memAddr, expAddr.pop_front());
                checkValue("store data", memWdata, expData.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (timerOn && cycleCount - runStart > cycleLimit) begin
            $display("timeout, the program did not finish within %0d cycles", cycleLimit);
            abortRun();
        end
    end

    task automatic abortRun();
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkValue(input string what, input word got, input word exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abortRun();
        end
    endtask

    function automatic word encR(input logic [4:0] rs, rt, rd, shamt, input logic [5:0] fn);
        return {opRtype, rs, rt, rd, shamt, fn};
    endfunction

    function automatic word encI(input logic [5:0] op, input logic [4:0] rs, rt,
                                 input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // true when the signed sum does not fit in 32 bits
    function automatic logic addOverflows(input word a, input word b);
        longint sum;
        sum = longint'($signed(a)) + longint'($signed(b));
        return sum != longint'($signed(sum[31:0]));
    endfunction

    // one instruction on the model registers and memory
    function automatic void refExec(input word instr, output logic hasStore,
                                    output word stAddr, output word stData,
                                    output logic trapped);
        logic [4:0] sh;
        logic [4:0] dest;
        logic       writes;
        word        a;
        word        b;
        word        imm;
        word        ea;
        word        res;
        sh       = instr[10:6];
        a        = modelRegs[instr[25:21]];
        b        = modelRegs[instr[20:16]];
        imm      = {{16{instr[15]}}, instr[15:0]};
        ea       = a + imm;
        dest     = instr[20:16];
        writes   = 1'b1;
        res      = '0;
        hasStore = 1'b0;
        stAddr   = '0;
        stData   = '0;
        trapped  = 1'b0;
        case (instr[31:26])
            opRtype: begin
                dest = instr[15:11];
                case (instr[5:0])
                    fnAdd: begin
                        res     = a + b;
                        trapped = addOverflows(a, b);
                    end
                    fnSll:   res = b << sh;
                    fnSrl:   res = b >> sh;
                    fnSra:   res = (b >> sh) | (b[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
                    default: trapped = 1'b1;
                endcase
            end
            opAddi: begin
                res     = ea;
                trapped = addOverflows(a, imm);
            end
            opAddiu: res = ea;
            opLw:    res = modelMem[ea[11:2]];
            opSw: begin
                writes   = 1'b0;
                hasStore = 1'b1;
                stAddr   = ea;
                stData   = b;
                modelMem[ea[11:2]] = b;
            end
            default: trapped = 1'b1;
        endcase
        if (writes && !trapped && dest != 5'd0)
            modelRegs[dest] = res;
    endfunction

    task automatic step(input word addr, input word instr);
        logic hasStore;
        logic trapped;
        word  stAddr;
        word  stData;
        refExec(instr, hasStore, stAddr, stData, trapped);
        if (hasStore) begin
            expAddr.push_back(stAddr);
            expData.push_back(stData);
        end
        if (trapped) begin
            halted    = 1'b1;
            faultAddr = addr;
        end
    endtask

    task automatic emit(input word instr);
        prog.push_back(instr);
        if (!halted)
            step(resetPc + 4 * (prog.size() - 1), instr);
    endtask

    task automatic emitHandler(input word instr);
        handler.push_back(instr);
        if (halted)  // handler runs only after a trap
            step(excVector + 4 * (handler.size() - 1), instr);
    endtask

    task automatic preload(input word addr, input word data);
        image[addr[11:2]]    = data;
        modelMem[addr[11:2]] = data;
    endtask

    task automatic clearRun();
        int i;
        for (i = 0; i < 1024; i++) begin
            image[i]    = '0;  // zero word decodes as a nop
            modelMem[i] = '0;
        end
        for (i = 0; i < 32; i++)
            modelRegs[i] = '0;
        prog.delete();
        handler.delete();
        expAddr.delete();
        expData.delete();
        halted    = 1'b0;
        faultAddr = '0;
    endtask

    task automatic applyReset();
        @(negedge clk);
        resetReq <= 1'b1;
        @(negedge clk);
        resetReq <= 1'b0;
        @(posedge arstN);
    endtask

    task automatic runProgram();
        int i;
        for (i = 0; i < prog.size(); i++)
            image[(resetPc >> 2) + i] = prog[i];
        for (i = 0; i < handler.size(); i++)
            image[(excVector >> 2) + i] = handler[i];
        cycleLimit = 9 * (prog.size() + handler.size()) + 50;
        applyReset();
        checkValue("first fetch address", memAddr, resetPc);
        checkValue("memWrite after reset", {31'b0, memWrite}, '0);
        runStart = cycleCount;
        timerOn  = 1'b1;
        if (halted) begin
            while (epc === '0)
                @(negedge clk);
            checkValue("epc", epc, faultAddr);
            checkValue("fetch address after trap", memAddr, excVector);
        end
        while (expAddr.size() != 0)
            @(negedge clk);
        timerOn = 1'b0;
    endtask

    task automatic buildAluSequence();
        int          k;
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
        for (k = 1; k <= 8; k++)
            emit(encI(opAddiu, 5'd0, 5'(k), 16'($urandom)));
        for (k = 0; k < 16; k++) begin
            rd   = 5'($urandom_range(8, 1));
            rs   = 5'($urandom_range(8, 0));
            rt   = 5'($urandom_range(8, 0));
            imm  = 16'($urandom);
            kind = $urandom_range(2, 0);
            // fall back to addiu where a signed add would overflow
            if (kind == 0 && !addOverflows(modelRegs[rs], modelRegs[rt]))
                emit(encR(rs, rt, rd, 5'd0, fnAdd));
            else if (kind == 1 && !addOverflows(modelRegs[rs], {{16{imm[15]}}, imm}))
                emit(encI(opAddi, rs, rd, imm));
            else
                emit(encI(opAddiu, rs, rd, imm));
        end
        for (k = 1; k <= 8; k++)
            emit(encI(opSw, 5'd0, 5'(k), 16'(32'h800 + 4 * k)));
    endtask

    task automatic buildLoadStore();
        int k;
        for (k = 0; k < 2; k++) begin
            preload(32'hC00 + 8 * k, $urandom);
            emit(encI(opLw, 5'd0, 5'd20, 16'(32'hC00 + 8 * k)));
            emit(encI(opAddiu, 5'd0, 5'd21, 16'(32'h900 + 16 * k)));
            emit(encI(opSw, 5'd21, 5'd20, 16'h0004));  // base plus offset
        end
    endtask

    task automatic buildShifts();
        int         k;
        word        value;
        logic [5:0] fn;
        for (k = 0; k < 6; k++) begin
            value     = $urandom;
            value[31] = k[0];  // each shift sees both signs
            fn        = (k < 2) ? fnSll : (k < 4) ? fnSrl : fnSra;
            preload(32'hD00 + 4 * k, value);
            emit(encI(opLw, 5'd0, 5'd22, 16'(32'hD00 + 4 * k)));
            emit(encR(5'd0, 5'd22, 5'd23, 5'($urandom_range(31, 1)), fn));
            emit(encI(opSw, 5'd0, 5'd23, 16'(32'hA00 + 4 * k)));
        end
    endtask

    task automatic buildOverflowTest();
        preload(32'hE00, 32'h4000_0000 | ($urandom & 32'h3FFF_FFFF));
        emit(encI(opAddiu, 5'd0, 5'd3, 16'($urandom)));
        emit(encI(opLw, 5'd0, 5'd1, 16'h0E00));
        emit(encR(5'd1, 5'd1, 5'd3, 5'd0, fnAdd));  // overflows so r3 keeps its old value
        emit(encI(opSw, 5'd0, 5'd3, 16'h0844));
        emitHandler(encI(opSw, 5'd0, 5'd3, 16'h0848));
    endtask

    task automatic buildUndefinedTest();
        emit(encI(opAddiu, 5'd0, 5'd5, 16'($urandom)));
        emit(encI(opAddiu, 5'd0, 5'd6, 16'($urandom)));
        emit(encR(5'd5, 5'd6, 5'd7, 5'd0, fnAdd));
        emit(encI(opSw, 5'd0, 5'd7, 16'h08C0));
        emit({6'h3F, 26'($urandom)});
        emit(encI(opSw, 5'd0, 5'd6, 16'h08C4));  // skipped by the trap
        emitHandler(encI(opSw, 5'd0, 5'd6, 16'h08C8));
    endtask

    initial begin
        void'($urandom(32'h8a14));
        clearRun();
        buildAluSequence();
        buildLoadStore();
        buildShifts();
        runProgram();
        clearRun();
        buildOverflowTest();
        runProgram();
        clearRun();
        buildUndefinedTest();
        runProgram();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: verification/clockGen.sv
`timescale 1ns/100ps

module clockGen #(
    parameter int halfPeriod  = 2,
    parameter int resetCycles = 5
) (
    input  logic resetReq,
    output logic clk,
    output logic arstN
);

    int lowLeft = resetCycles;  // reset active from time zero

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // reset changes on the falling edge only
    always @(negedge clk) begin
        if (resetReq)
            lowLeft <= resetCycles;
        else if (lowLeft != 0)
            lowLeft <= lowLeft - 1;
    end

    assign arstN = (lowLeft == 0);

endmodule

// File: logic/mipsCore.sv
`timescale 1ns/100ps

module mipsCore import mipsPkg::*; #(
    parameter word resetPc   = 32'h0,
    parameter word excVector = 32'h400
) (
    input  logic clk,
    input  logic arstN,
    input  word  memRdata,
    output word  memAddr,
    output word  memWdata,
    output word  epc,
    output logic memWrite
);

    logic       pcWrite, pcFromVector, irWrite, abLoad, mdrLoad, aluOutWrite;
    logic       epcWrite, regWrite, addrFromAluOut, destIsRd, overflow;
    logic [5:0] opcode, funct;
    aSelT       aSel;
    bSelT       bSel;
    aluOpT      aluOp;
    shiftOpT    shiftOp;
    wbSelT      wbSel;

    multiCycleControl u_control (
        .clk(clk), .arstN(arstN), .opcode(opcode), .funct(funct), .overflow(overflow),
        .pcWrite(pcWrite), .pcFromVector(pcFromVector), .irWrite(irWrite),
        .abLoad(abLoad), .mdrLoad(mdrLoad), .aluOutWrite(aluOutWrite),
        .epcWrite(epcWrite), .regWrite(regWrite), .memWrite(memWrite),
        .addrFromAluOut(addrFromAluOut), .destIsRd(destIsRd), .aSel(aSel),
        .bSel(bSel), .aluOp(aluOp), .shiftOp(shiftOp), .wbSel(wbSel)
    );

    instrDatapath #(.resetPc(resetPc), .excVector(excVector)) u_datapath (
        .clk(clk), .arstN(arstN), .memRdata(memRdata), .pcWrite(pcWrite),
        .pcFromVector(pcFromVector), .irWrite(irWrite), .abLoad(abLoad),
        .mdrLoad(mdrLoad), .aluOutWrite(aluOutWrite), .epcWrite(epcWrite),
        .regWrite(regWrite), .addrFromAluOut(addrFromAluOut), .destIsRd(destIsRd),
        .aSel(aSel), .bSel(bSel), .aluOp(aluOp), .shiftOp(shiftOp), .wbSel(wbSel),
        .memAddr(memAddr), .memWdata(memWdata), .epc(epc), .opcode(opcode),
        .funct(funct), .overflow(overflow)
    );

endmodule

// File: logic/instrDatapath.sv
`timescale 1ns/100ps

module instrDatapath import mipsPkg::*; #(
    parameter word resetPc   = 32'h0,
    parameter word excVector = 32'h400
) (
    input  logic       clk,
    input  logic       arstN,
    input  word        memRdata,
    input  logic       pcWrite,
    input  logic       pcFromVector,
    input  logic       irWrite,
    input  logic       abLoad,
    input  logic       mdrLoad,
    input  logic       aluOutWrite,
    input  logic       epcWrite,
    input  logic       regWrite,
    input  logic       addrFromAluOut,
    input  logic       destIsRd,
    input  aSelT       aSel,
    input  bSelT       bSel,
    input  aluOpT      aluOp,
    input  shiftOpT    shiftOp,
    input  wbSelT      wbSel,
    output word        memAddr,
    output word        memWdata,
    output word        epc,
    output logic [5:0] opcode,
    output logic [5:0] funct,
    output logic       overflow
);

    word        pc, ir, mdr, regA, regB, aluOut;
    word        rdataA, rdataB, aluA, aluB, aluResult, shiftResult;
    word        immExt, wbData, pcMinus4;
    logic [4:0] waddr;

    assign opcode   = ir[31:26];
    assign funct    = ir[5:0];
    assign immExt   = {{16{ir[15]}}, ir[15:0]};
    assign pcMinus4 = pc - 32'd4;
    assign waddr    = destIsRd ? ir[15:11] : ir[20:16];

    // pc has already moved on once fetch is over
    assign memAddr  = addrFromAluOut ? aluOut : (pcWrite ? pc : pcMinus4);
    assign memWdata = regB;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc  <= resetPc;
            epc <= '0;
        end else begin
            if (pcWrite)
                pc <= pcFromVector ? excVector : aluResult;
            if (epcWrite)
                epc <= pcMinus4;  // address of the faulting instruction
        end
    end

    always_ff @(posedge clk) begin
        if (irWrite)
            ir <= memRdata;
        if (mdrLoad)
            mdr <= memRdata;
        if (abLoad) begin
            regA <= rdataA;
            regB <= rdataB;
        end
        if (aluOutWrite)
            aluOut <= aluResult;
    end

    assign aluA = (aSel == aPc) ? pc : regA;

    always_comb begin
        case (bSel)
            bReg:    aluB = regB;
            bFour:   aluB = 32'd4;
            default: aluB = immExt;
        endcase
        case (wbSel)
            wbMdr:   wbData = mdr;
            wbShift: wbData = shiftResult;
            default: wbData = aluOut;
        endcase
    end

    registerFile u_regFile (
        .clk(clk), .arstN(arstN), .raddrA(ir[25:21]), .raddrB(ir[20:16]),
        .waddr(waddr), .wdata(wbData), .we(regWrite), .rdataA(rdataA), .rdataB(rdataB)
    );

    aluUnit u_alu (
        .a(aluA), .b(aluB), .aluOp(aluOp), .result(aluResult), .overflow(overflow)
    );

    barrelShifter u_shifter (
        .value(regB), .shamt(ir[10:6]), .shiftOp(shiftOp), .result(shiftResult)
    );

endmodule

// File: logic/multiCycleControl.sv
`timescale 1ns/100ps

module multiCycleControl import mipsPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    input  logic       overflow,
    output logic       pcWrite,
    output logic       pcFromVector,
    output logic       irWrite,
    output logic       abLoad,
    output logic       mdrLoad,
    output logic       aluOutWrite,
    output logic       epcWrite,
    output logic       regWrite,
    output logic       memWrite,
    output logic       addrFromAluOut,
    output logic       destIsRd,
    output aSelT       aSel,
    output bSelT       bSel,
    output aluOpT      aluOp,
    output shiftOpT    shiftOp,
    output wbSelT      wbSel
);

    ctrlStateT state;
    ctrlStateT nextState;
    logic      isRtype;
    logic      isAdd;
    logic      isShift;
    logic      isImmAlu;
    logic      isMem;
    shiftOpT   shiftDec;

    assign isRtype  = (opcode == opRtype);
    assign isAdd    = isRtype && (funct == fnAdd);
    assign isShift  = isRtype && (funct == fnSll || funct == fnSrl || funct == fnSra);
    assign isImmAlu = (opcode == opAddi) || (opcode == opAddiu);
    assign isMem    = (opcode == opLw) || (opcode == opSw);

    always_comb begin
        case (funct)
            fnSrl:   shiftDec = shiftRightLogic;
            fnSra:   shiftDec = shiftRightArith;
            default: shiftDec = shiftLeft;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= fetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = fetch;
        case (state)
            fetch:     nextState = fetchWait;
            fetchWait: nextState = irLoad;
            irLoad:    nextState = decode;
            decode: begin
                if (isAdd || isImmAlu)
                    nextState = aluExec;
                else if (isMem)
                    nextState = memAddr;
                else if (isShift)
                    nextState = shiftExec;
                else
                    nextState = trap;  // undefined opcode or funct
            end
            aluExec:   nextState = overflow ? trap : aluWrite;
            memAddr:   nextState = (opcode == opSw) ? storeWrite : memRead;
            memRead:   nextState = memWait;
            memWait:   nextState = mipsPkg::mdrLoad;  // port of the same name shadows it
            mipsPkg::mdrLoad: nextState = loadWrite;
            shiftExec: nextState = shiftWrite;
            default:   nextState = fetch;
        endcase
    end

    always_comb begin
        pcWrite        = 1'b0;
        pcFromVector   = 1'b0;
        irWrite        = 1'b0;
        abLoad         = 1'b0;
        mdrLoad        = 1'b0;
        aluOutWrite    = 1'b0;
        epcWrite       = 1'b0;
        regWrite       = 1'b0;
        memWrite       = 1'b0;
        addrFromAluOut = 1'b0;
        destIsRd       = 1'b0;
        aSel           = aPc;
        bSel           = bFour;
        aluOp          = addUnsigned;
        shiftOp        = shiftLeft;
        wbSel          = wbAluOut;
        case (state)
            fetch:   pcWrite = 1'b1;  // pc + 4
            irLoad:  irWrite = 1'b1;
            decode:  abLoad  = 1'b1;
            aluExec: begin
                aSel        = aReg;
                bSel        = isRtype ? bReg : bImm;
                aluOp       = (opcode == opAddiu) ? addUnsigned : add;
                aluOutWrite = 1'b1;
            end
            aluWrite: begin
                regWrite = 1'b1;
                destIsRd = isRtype;
            end
            memAddr: begin
                aSel        = aReg;
                bSel        = bImm;
                aluOutWrite = 1'b1;
            end
            memRead, memWait: addrFromAluOut = 1'b1;  // hold address for the read
            mipsPkg::mdrLoad: mdrLoad = 1'b1;
            loadWrite: begin
                regWrite = 1'b1;
                wbSel    = wbMdr;
            end
            storeWrite: begin
                addrFromAluOut = 1'b1;
                memWrite       = 1'b1;
            end
            shiftExec: shiftOp = shiftDec;
            shiftWrite: begin
                shiftOp  = shiftDec;
                wbSel    = wbShift;
                destIsRd = 1'b1;
                regWrite = 1'b1;
            end
            trap: begin
                epcWrite     = 1'b1;
                pcWrite      = 1'b1;
                pcFromVector = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: logic/barrelShifter.sv
`timescale 1ns/100ps

module barrelShifter import mipsPkg::*; (
    input  word        value,
    input  logic [4:0] shamt,
    input  shiftOpT    shiftOp,
    output word        result
);

    always_comb begin
        case (shiftOp)
            shiftLeft:       result = value << shamt;
            shiftRightLogic: result = value >> shamt;   // zero fill
            shiftRightArith: result = word'($signed(value) >>> shamt);
            default:         result = value;
        endcase
    end

endmodule

// File: logic/aluUnit.sv
`timescale 1ns/100ps

module aluUnit import mipsPkg::*; (
    input  word   a,
    input  word   b,
    input  aluOpT aluOp,
    output word   result,
    output logic  overflow
);

    word  sum;
    logic signedOvf;

    assign sum = a + b;

    // operands agree in sign, sum does not
    assign signedOvf = (a[31] == b[31]) && (sum[31] != a[31]);

    always_comb begin
        result   = sum;
        overflow = 1'b0;
        case (aluOp)
            add: begin
                result   = sum;
                overflow = signedOvf;
            end
            addUnsigned: result = sum;
            passB:       result = b;
            default:     result = sum;
        endcase
    end

endmodule

// File: logic/registerFile.sv
`timescale 1ns/100ps

module registerFile import mipsPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  logic [4:0] raddrA,
    input  logic [4:0] raddrB,
    input  logic [4:0] waddr,
    input  word        wdata,
    input  logic       we,
    output word        rdataA,
    output word        rdataB
);

    word regs [32];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 always reads zero
    assign rdataA = (raddrA == 5'd0) ? '0 : regs[raddrA];
    assign rdataB = (raddrB == 5'd0) ? '0 : regs[raddrB];

endmodule

// File: logic/mipsPkg.sv
package mipsPkg;

    typedef logic [31:0] word;

    // primary opcodes
    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    // r-type funct codes
    localparam logic [5:0] fnSll = 6'h00;
    localparam logic [5:0] fnSrl = 6'h02;
    localparam logic [5:0] fnSra = 6'h03;
    localparam logic [5:0] fnAdd = 6'h20;

    typedef enum logic [1:0] {
        add,
        addUnsigned,
        passB
    } aluOpT;

    typedef enum logic [1:0] {
        shiftLeft,
        shiftRightLogic,
        shiftRightArith
    } shiftOpT;

    typedef enum logic [1:0] {aPc, aReg} aSelT;
    typedef enum logic [1:0] {bReg, bFour, bImm} bSelT;
    typedef enum logic [1:0] {wbAluOut, wbMdr, wbShift} wbSelT;

    typedef enum logic [4:0] {
        fetch,
        fetchWait,
        irLoad,
        decode,
        aluExec,
        aluWrite,
        memAddr,
        memRead,
        memWait,
        mdrLoad,
        loadWrite,
        storeWrite,
        shiftExec,
        shiftWrite,
        trap
    } ctrlStateT;

endpackage
